/* rtl/rv_pkg.sv */
package rv_pkg;

  // Datapath and register index widths
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // Memory sizes in 32-bit words
  localparam int rom_depth = 64;
  localparam int ram_depth = 64;

  // Decode buffer entries, which is also the fetch credit count after reset
  localparam int ibuf_depth = 2;

  // 1 forwards MEM and WB results into EX, 0 stalls in ID on any EX or MEM producer
  localparam int fwd_en = 1;

  // Major opcodes of the supported subset
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;

  // Function fields; LW and SW both use the word size code
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_bne = 3'b001;
  localparam logic [2:0] f3_word = 3'b010;
  localparam logic [6:0] f7_sub = 7'b0100000;

  // One instruction word seen as R format or as I format
  // S and B immediates are rebuilt from the funct7 and rd fields of the r view
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } rv_instr_u;

endpackage

/* rtl/rv_fetch.sv */
module rv_fetch (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    redir_valid,
  input  logic [rv_pkg::xlen-1:0] redir_pc,
  input  logic [1:0]              credit_ret_n,
  output logic                    instr_valid,
  output rv_pkg::rv_instr_u       instr,
  output logic [rv_pkg::xlen-1:0] instr_pc
);

  // Counter must hold every value from zero up to the buffer depth
  localparam int cw = $clog2(rv_pkg::ibuf_depth + 1);
  localparam int rom_aw = $clog2(rv_pkg::rom_depth);

  logic [rv_pkg::xlen-1:0] rom [rv_pkg::rom_depth];
  logic [rv_pkg::xlen-1:0] pc;
  logic [cw-1:0]           credits;
  logic                    in_range;

  initial begin
    $readmemh("program.hex", rom);
  end

  // Words beyond the ROM read as zero, which the decoder treats as a no-op
  assign in_range = (pc[rv_pkg::xlen-1:2] < rv_pkg::rom_depth);
  assign instr = in_range ? rom[pc[rom_aw+1:2]] : '0;
  assign instr_pc = pc;

  // A send needs a free buffer slot downstream and no redirect in progress
  assign instr_valid = (credits != '0) && !redir_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (redir_valid) begin
      // Fetch restarts at the branch target on the following cycle
      pc <= redir_pc;
    end else if (instr_valid) begin
      pc <= pc + rv_pkg::xlen'(4);
    end
  end

  // Credits returned by decode in one cycle are usable in the next
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits <= cw'(rv_pkg::ibuf_depth);
    end else begin
      credits <= credits - cw'(instr_valid) + cw'(credit_ret_n);
    end
  end

endmodule

/* rtl/rv_decode.sv */
module rv_decode (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          instr_valid,
  input  rv_pkg::rv_instr_u             instr,
  input  logic [rv_pkg::xlen-1:0]       instr_pc,
  input  logic                          data_hazard_id,
  input  logic                          if_id_flush,
  input  logic                          id_ex_flush,
  input  logic                          wb_we,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  output logic [1:0]                    credit_ret_n,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_id,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_id,
  output logic                          rs1_used_id,
  output logic                          rs2_used_id,
  output logic                          ex_valid,
  output logic                          ex_alu_sub,
  output logic                          ex_use_imm,
  output logic                          ex_is_ld,
  output logic                          ex_is_st,
  output logic                          ex_is_br,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rd,
  output logic                          ex_reg_write,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
  output logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
  output logic [rv_pkg::xlen-1:0]       ex_rs1_val,
  output logic [rv_pkg::xlen-1:0]       ex_rs2_val,
  output logic [rv_pkg::xlen-1:0]       ex_imm,
  output logic [rv_pkg::xlen-1:0]       ex_pc
);

  // Entry 0 is always the head, entry 1 only fills behind a valid head
  logic                    v0;
  logic                    v1;
  rv_pkg::rv_instr_u       b0_instr;
  rv_pkg::rv_instr_u       b1_instr;
  logic [rv_pkg::xlen-1:0] b0_pc;
  logic [rv_pkg::xlen-1:0] b1_pc;
  logic                    pop;
  logic                    shift;
  logic                    wr0;
  logic                    wr1;
  logic [rv_pkg::xlen-1:0] rf [2**rv_pkg::reg_addr_w];
  logic                    is_reg;
  logic                    is_addi;
  logic                    is_ld;
  logic                    is_st;
  logic                    is_br;
  logic [rv_pkg::xlen-1:0] imm;
  logic [rv_pkg::xlen-1:0] rs1_val;
  logic [rv_pkg::xlen-1:0] rs2_val;

  // The head moves to EX unless it waits on a hazard or is being flushed
  assign pop = v0 && !data_hazard_id && !id_ex_flush;
  assign shift = pop && v1;
  assign wr0 = instr_valid && (pop ? !v1 : !v0);
  assign wr1 = instr_valid && (pop ? v1 : v0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      v0 <= 1'b0;
      v1 <= 1'b0;
    end else if (if_id_flush) begin
      v0 <= 1'b0;
      v1 <= 1'b0;
    end else begin
      v0 <= pop ? (v1 || instr_valid) : (v0 || instr_valid);
      v1 <= pop ? (v1 && instr_valid) : (v1 || (v0 && instr_valid));
    end
  end

  always_ff @(posedge clk) begin
    if (wr0) begin
      b0_instr <= instr;
      b0_pc <= instr_pc;
    end else if (shift) begin
      b0_instr <= b1_instr;
      b0_pc <= b1_pc;
    end
    if (wr1) begin
      b1_instr <= instr;
      b1_pc <= instr_pc;
    end
  end

  // A flush hands back every discarded slot, including one arriving this cycle
  assign credit_ret_n = if_id_flush ? (2'(v0) + 2'(v1) + 2'(instr_valid)) : {1'b0, pop};

  // Anything outside the subset leaves every flag low and acts as a no-op
  assign is_reg = v0 && (b0_instr.r.opcode == rv_pkg::op_reg)
                  && (b0_instr.r.funct3 == rv_pkg::f3_add)
                  && ((b0_instr.r.funct7 == '0) || (b0_instr.r.funct7 == rv_pkg::f7_sub));
  assign is_addi = v0 && (b0_instr.i.opcode == rv_pkg::op_imm)
                   && (b0_instr.i.funct3 == rv_pkg::f3_add);
  assign is_ld = v0 && (b0_instr.i.opcode == rv_pkg::op_load)
                 && (b0_instr.i.funct3 == rv_pkg::f3_word);
  assign is_st = v0 && (b0_instr.r.opcode == rv_pkg::op_store)
                 && (b0_instr.r.funct3 == rv_pkg::f3_word);
  assign is_br = v0 && (b0_instr.r.opcode == rv_pkg::op_branch)
                 && (b0_instr.r.funct3 == rv_pkg::f3_bne);

  assign rs1_id = b0_instr.r.rs1;
  assign rs2_id = b0_instr.r.rs2;
  assign rs1_used_id = is_reg || is_addi || is_ld || is_st || is_br;
  assign rs2_used_id = is_reg || is_st || is_br;

  // S splits its offset over funct7 and rd, B scrambles the same bits with bit 0 fixed
  always_comb begin
    if (is_st) begin
      imm = {{20{b0_instr.r.funct7[6]}}, b0_instr.r.funct7, b0_instr.r.rd};
    end else if (is_br) begin
      imm = {{20{b0_instr.r.funct7[6]}}, b0_instr.r.rd[0], b0_instr.r.funct7[5:0],
             b0_instr.r.rd[4:1], 1'b0};
    end else begin
      imm = {{20{b0_instr.i.imm12[11]}}, b0_instr.i.imm12};
    end
  end

  always_ff @(posedge clk) begin
    if (wb_we && (wb_rd != '0)) begin
      rf[wb_rd] <= wb_data;
    end
  end

  // Write-before-read, so a result in WB is seen by ID in the same cycle
  assign rs1_val = (rs1_id == '0) ? '0 : ((wb_we && (wb_rd == rs1_id)) ? wb_data : rf[rs1_id]);
  assign rs2_val = (rs2_id == '0) ? '0 : ((wb_we && (wb_rd == rs2_id)) ? wb_data : rf[rs2_id]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= pop;
    end
  end

  // Payload only matters when ex_valid is set, so it loads on a pop alone
  always_ff @(posedge clk) begin
    if (pop) begin
      ex_alu_sub <= is_reg && (b0_instr.r.funct7 == rv_pkg::f7_sub);
      ex_use_imm <= is_addi || is_ld || is_st;
      ex_is_ld <= is_ld;
      ex_is_st <= is_st;
      ex_is_br <= is_br;
      ex_rd <= b0_instr.r.rd;
      ex_reg_write <= (is_reg || is_addi || is_ld) && (b0_instr.r.rd != '0);
      ex_rs1 <= rs1_id;
      ex_rs2 <= rs2_id;
      ex_rs1_val <= rs1_val;
      ex_rs2_val <= rs2_val;
      ex_imm <= imm;
      ex_pc <= b0_pc;
    end
  end

endmodule

/* rtl/rv_hazard.sv */
module rv_hazard (
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_id,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_id,
  input  logic                          rs1_used_id,
  input  logic                          rs2_used_id,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_ex,
  input  logic                          reg_write_ex,
  input  logic                          is_ld_ex,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_mem,
  input  logic                          reg_write_mem,
  input  logic                          redir_valid,
  output logic                          data_hazard_id,
  output logic                          if_id_flush,
  output logic                          id_ex_flush
);

  logic ex_hit;
  logic mem_hit;
  logic load_use;
  logic raw_stall;

  // x0 never carries a dependency, whatever the producer claims
  assign ex_hit = reg_write_ex && (rd_ex != '0)
                  && ((rs1_used_id && (rd_ex == rs1_id)) || (rs2_used_id && (rd_ex == rs2_id)));
  assign mem_hit = reg_write_mem && (rd_mem != '0)
                   && ((rs1_used_id && (rd_mem == rs1_id)) || (rs2_used_id && (rd_mem == rs2_id)));

  // A load's data only exists once it reaches WB, so a consumer right behind it waits
  assign load_use = is_ld_ex && ex_hit;

  // Without forwarding every EX or MEM producer holds the consumer in ID
  assign raw_stall = (rv_pkg::fwd_en != 0) ? load_use : (ex_hit || mem_hit);

  // The consumer is discarded on a redirect, so holding it would only block the flush
  assign data_hazard_id = raw_stall && !redir_valid;

  // A taken branch in EX kills the buffer and the instruction waiting in ID
  assign if_id_flush = redir_valid;
  assign id_ex_flush = redir_valid;

endmodule

/* rtl/rv_execute.sv */
module rv_execute (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          ex_valid,
  input  logic                          ex_alu_sub,
  input  logic                          ex_use_imm,
  input  logic                          ex_is_ld,
  input  logic                          ex_is_st,
  input  logic                          ex_is_br,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rd,
  input  logic                          ex_reg_write,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
  input  logic [rv_pkg::xlen-1:0]       ex_rs1_val,
  input  logic [rv_pkg::xlen-1:0]       ex_rs2_val,
  input  logic [rv_pkg::xlen-1:0]       ex_imm,
  input  logic [rv_pkg::xlen-1:0]       ex_pc,
  input  logic                          wb_we,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  output logic [rv_pkg::reg_addr_w-1:0] rd_ex,
  output logic                          reg_write_ex,
  output logic                          is_ld_ex,
  output logic                          redir_valid,
  output logic [rv_pkg::xlen-1:0]       redir_pc,
  output logic                          mem_valid,
  output logic                          mem_is_ld,
  output logic                          mem_is_st,
  output logic [rv_pkg::reg_addr_w-1:0] mem_rd,
  output logic                          mem_reg_write,
  output logic [rv_pkg::xlen-1:0]       mem_result,
  output logic [rv_pkg::xlen-1:0]       mem_store_data
);

  logic                    mem_fwd_ok;
  logic                    wb_fwd_ok;
  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] rs2_fwd;
  logic [rv_pkg::xlen-1:0] op_b;
  logic [rv_pkg::xlen-1:0] alu_out;

  assign rd_ex = ex_rd;
  assign reg_write_ex = ex_valid && ex_reg_write;
  assign is_ld_ex = ex_valid && ex_is_ld;

  // MEM holds only an address for a load, so only ALU results forward from there
  assign mem_fwd_ok = (rv_pkg::fwd_en != 0) && mem_valid && mem_reg_write && !mem_is_ld;
  assign wb_fwd_ok = (rv_pkg::fwd_en != 0) && wb_we && (wb_rd != '0);

  // The younger producer in MEM wins over the one in WB
  always_comb begin
    op_a = ex_rs1_val;
    if (mem_fwd_ok && (mem_rd == ex_rs1)) begin
      op_a = mem_result;
    end else if (wb_fwd_ok && (wb_rd == ex_rs1)) begin
      op_a = wb_data;
    end
    rs2_fwd = ex_rs2_val;
    if (mem_fwd_ok && (mem_rd == ex_rs2)) begin
      rs2_fwd = mem_result;
    end else if (wb_fwd_ok && (wb_rd == ex_rs2)) begin
      rs2_fwd = wb_data;
    end
  end

  // Loads and stores reuse the adder to form their address
  assign op_b = ex_use_imm ? ex_imm : rs2_fwd;
  assign alu_out = ex_alu_sub ? (op_a - op_b) : (op_a + op_b);

  // BNE compares the forwarded register values and jumps relative to its own pc
  assign redir_valid = ex_valid && ex_is_br && (op_a != rs2_fwd);
  assign redir_pc = ex_pc + ex_imm;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_valid <= 1'b0;
      mem_is_ld <= 1'b0;
      mem_is_st <= 1'b0;
      mem_reg_write <= 1'b0;
    end else begin
      mem_valid <= ex_valid;
      mem_is_ld <= ex_valid && ex_is_ld;
      mem_is_st <= ex_valid && ex_is_st;
      mem_reg_write <= ex_valid && ex_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    mem_rd <= ex_rd;
    mem_result <= alu_out;
    mem_store_data <= rs2_fwd;
  end

endmodule

/* rtl/rv_memory.sv */
module rv_memory (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          mem_valid,
  input  logic                          mem_is_ld,
  input  logic                          mem_is_st,
  input  logic [rv_pkg::reg_addr_w-1:0] mem_rd,
  input  logic                          mem_reg_write,
  input  logic [rv_pkg::xlen-1:0]       mem_result,
  input  logic [rv_pkg::xlen-1:0]       mem_store_data,
  output logic                          wb_we,
  output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          retire_valid,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_data
);

  localparam int ram_aw = $clog2(rv_pkg::ram_depth);

  logic [rv_pkg::xlen-1:0] ram [rv_pkg::ram_depth];
  logic [ram_aw-1:0]       word_idx;
  logic [rv_pkg::xlen-1:0] ld_data;

  // Byte address to word index; upper bits wrap inside the RAM
  assign word_idx = mem_result[ram_aw+1:2];
  assign ld_data = ram[word_idx];

  // A store lands at the end of its MEM cycle, before any later load reads
  always_ff @(posedge clk) begin
    if (mem_valid && mem_is_st) begin
      ram[word_idx] <= mem_store_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_we <= 1'b0;
    end else begin
      wb_we <= mem_valid && mem_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd <= mem_rd;
    wb_data <= mem_is_ld ? ld_data : mem_result;
  end

  // Decode drops x0 writes, so every register write in WB is reported once
  assign retire_valid = wb_we;
  assign retire_rd = wb_rd;
  assign retire_data = wb_data;

endmodule

/* rtl/rv_core.sv */
module rv_core (
  input  logic                          clk,
  input  logic                          arst_n,
  output logic                          retire_valid,
  output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_pkg::xlen-1:0]       retire_data
);

  // Fetch to decode with credit return
  logic                          instr_valid;
  rv_pkg::rv_instr_u             instr;
  logic [rv_pkg::xlen-1:0]       instr_pc;
  logic [1:0]                    credit_ret_n;

  // Hazard unit connections
  logic [rv_pkg::reg_addr_w-1:0] rs1_id;
  logic [rv_pkg::reg_addr_w-1:0] rs2_id;
  logic                          rs1_used_id;
  logic                          rs2_used_id;
  logic [rv_pkg::reg_addr_w-1:0] rd_ex;
  logic                          reg_write_ex;
  logic                          is_ld_ex;
  logic                          data_hazard_id;
  logic                          if_id_flush;
  logic                          id_ex_flush;
  logic                          redir_valid;
  logic [rv_pkg::xlen-1:0]       redir_pc;

  // ID/EX register
  logic                          ex_valid;
  logic                          ex_alu_sub;
  logic                          ex_use_imm;
  logic                          ex_is_ld;
  logic                          ex_is_st;
  logic                          ex_is_br;
  logic [rv_pkg::reg_addr_w-1:0] ex_rd;
  logic                          ex_reg_write;
  logic [rv_pkg::reg_addr_w-1:0] ex_rs1;
  logic [rv_pkg::reg_addr_w-1:0] ex_rs2;
  logic [rv_pkg::xlen-1:0]       ex_rs1_val;
  logic [rv_pkg::xlen-1:0]       ex_rs2_val;
  logic [rv_pkg::xlen-1:0]       ex_imm;
  logic [rv_pkg::xlen-1:0]       ex_pc;

  // EX/MEM register and the writeback port
  logic                          mem_valid;
  logic                          mem_is_ld;
  logic                          mem_is_st;
  logic [rv_pkg::reg_addr_w-1:0] mem_rd;
  logic                          mem_reg_write;
  logic [rv_pkg::xlen-1:0]       mem_result;
  logic [rv_pkg::xlen-1:0]       mem_store_data;
  logic                          wb_we;
  logic [rv_pkg::reg_addr_w-1:0] wb_rd;
  logic [rv_pkg::xlen-1:0]       wb_data;

  rv_fetch u_rv_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .redir_valid (redir_valid),
    .redir_pc    (redir_pc),
    .credit_ret_n(credit_ret_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_pc    (instr_pc)
  );

  rv_decode u_rv_decode (
    .clk           (clk),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .instr_pc      (instr_pc),
    .data_hazard_id(data_hazard_id),
    .if_id_flush   (if_id_flush),
    .id_ex_flush   (id_ex_flush),
    .wb_we         (wb_we),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .credit_ret_n  (credit_ret_n),
    .rs1_id        (rs1_id),
    .rs2_id        (rs2_id),
    .rs1_used_id   (rs1_used_id),
    .rs2_used_id   (rs2_used_id),
    .ex_valid      (ex_valid),
    .ex_alu_sub    (ex_alu_sub),
    .ex_use_imm    (ex_use_imm),
    .ex_is_ld      (ex_is_ld),
    .ex_is_st      (ex_is_st),
    .ex_is_br      (ex_is_br),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .ex_rs1        (ex_rs1),
    .ex_rs2        (ex_rs2),
    .ex_rs1_val    (ex_rs1_val),
    .ex_rs2_val    (ex_rs2_val),
    .ex_imm        (ex_imm),
    .ex_pc         (ex_pc)
  );

  rv_hazard u_rv_hazard (
    .rs1_id        (rs1_id),
    .rs2_id        (rs2_id),
    .rs1_used_id   (rs1_used_id),
    .rs2_used_id   (rs2_used_id),
    .rd_ex         (rd_ex),
    .reg_write_ex  (reg_write_ex),
    .is_ld_ex      (is_ld_ex),
    .rd_mem        (mem_rd),
    .reg_write_mem (mem_valid && mem_reg_write),
    .redir_valid   (redir_valid),
    .data_hazard_id(data_hazard_id),
    .if_id_flush   (if_id_flush),
    .id_ex_flush   (id_ex_flush)
  );

  rv_execute u_rv_execute (
    .clk           (clk),
    .arst_n        (arst_n),
    .ex_valid      (ex_valid),
    .ex_alu_sub    (ex_alu_sub),
    .ex_use_imm    (ex_use_imm),
    .ex_is_ld      (ex_is_ld),
    .ex_is_st      (ex_is_st),
    .ex_is_br      (ex_is_br),
    .ex_rd         (ex_rd),
    .ex_reg_write  (ex_reg_write),
    .ex_rs1        (ex_rs1),
    .ex_rs2        (ex_rs2),
    .ex_rs1_val    (ex_rs1_val),
    .ex_rs2_val    (ex_rs2_val),
    .ex_imm        (ex_imm),
    .ex_pc         (ex_pc),
    .wb_we         (wb_we),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .rd_ex         (rd_ex),
    .reg_write_ex  (reg_write_ex),
    .is_ld_ex      (is_ld_ex),
    .redir_valid   (redir_valid),
    .redir_pc      (redir_pc),
    .mem_valid     (mem_valid),
    .mem_is_ld     (mem_is_ld),
    .mem_is_st     (mem_is_st),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .mem_result    (mem_result),
    .mem_store_data(mem_store_data)
  );

  rv_memory u_rv_memory (
    .clk           (clk),
    .arst_n        (arst_n),
    .mem_valid     (mem_valid),
    .mem_is_ld     (mem_is_ld),
    .mem_is_st     (mem_is_st),
    .mem_rd        (mem_rd),
    .mem_reg_write (mem_reg_write),
    .mem_result    (mem_result),
    .mem_store_data(mem_store_data),
    .wb_we         (wb_we),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .retire_valid  (retire_valid),
    .retire_rd     (retire_rd),
    .retire_data   (retire_data)
  );

endmodule

/* testbench/rv_core_checker.sv */
module rv_core_checker (
  input logic                          clk,
  input logic                          arst_n,
  input logic                          instr_valid,
  input logic [1:0]                    credit_ret_n,
  input logic [rv_pkg::reg_addr_w-1:0] rs1_id,
  input logic [rv_pkg::reg_addr_w-1:0] rs2_id,
  input logic                          rs1_used_id,
  input logic                          rs2_used_id,
  input logic [rv_pkg::reg_addr_w-1:0] rd_ex,
  input logic                          reg_write_ex,
  input logic                          is_ld_ex,
  input logic                          data_hazard_id,
  input logic                          redir_valid,
  input logic                          ex_valid,
  input logic                          mem_valid,
  input logic                          wb_we,
  input logic                          retire_valid,
  input logic [rv_pkg::reg_addr_w-1:0] retire_rd
);

  // Failures seen so far, read by the testbench at the end of the run
  int fail_cnt = 0;

  // Shadow of the fetch credit counter, one bit wider so an overflow stays visible
  logic [2:0] credits_seen;
  logic       alu_dep;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      credits_seen <= 3'(rv_pkg::ibuf_depth);
    end else begin
      credits_seen <= credits_seen - 3'(instr_valid) + 3'(credit_ret_n);
    end
  end

  // The ID head reads a register that an ALU instruction in EX is about to write
  assign alu_dep = (rv_pkg::fwd_en != 0) && reg_write_ex && !is_ld_ex && (rd_ex != '0)
                   && ((rs1_used_id && (rs1_id == rd_ex)) || (rs2_used_id && (rs2_id == rd_ex)));

  // Decode never holds more entries than it granted credits for
  a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
    credits_seen <= 3'(rv_pkg::ibuf_depth))
    else begin
      $error("Fetch credit count rose above the buffer depth");
      fail_cnt++;
    end

  a_send_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
    instr_valid |-> (credits_seen != '0))
    else begin
      $error("Fetch sent an instruction with no credit left");
      fail_cnt++;
    end

  // A stalled head must not slip into EX on the following edge
  a_stall_blocks_ex: assert property (@(posedge clk) disable iff (!arst_n)
    data_hazard_id |=> !ex_valid)
    else begin
      $error("An instruction entered EX during a data stall");
      fail_cnt++;
    end

  // A load-use stall lasts one cycle with forwarding and at most two without
  a_stall_length: assert property (@(posedge clk) disable iff (!arst_n)
    (data_hazard_id && ((rv_pkg::fwd_en != 0) || $past(data_hazard_id))) |=> !data_hazard_id)
    else begin
      $error("Data stall held the consumer in ID for too many cycles");
      fail_cnt++;
    end

  // Dependent ALU pairs follow each other through EX with no bubble
  a_alu_back_to_back: assert property (@(posedge clk) disable iff (!arst_n)
    alu_dep |=> ex_valid)
    else begin
      $error("Dependent ALU instruction did not follow its producer into EX");
      fail_cnt++;
    end

  // The ID head and the buffer behind it are both discarded, so EX sees two bubbles
  a_flush_on_redirect: assert property (@(posedge clk) disable iff (!arst_n)
    (redir_valid || $past(redir_valid)) |=> !ex_valid)
    else begin
      $error("Taken branch did not flush the buffer and the ID stage");
      fail_cnt++;
    end

  a_no_x0_retire: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |-> (retire_rd != '0))
    else begin
      $error("Retire port reported a write to x0");
      fail_cnt++;
    end

  // Valid bits stay low while reset is held
  a_reset_quiet: assert property (@(posedge clk)
    !arst_n |-> (!ex_valid && !mem_valid && !wb_we && !retire_valid && !redir_valid))
    else begin
      $error("A pipeline valid bit was high during reset");
      fail_cnt++;
    end

endmodule

bind rv_core rv_core_checker u_rv_core_checker (
  .clk           (clk),
  .arst_n        (arst_n),
  .instr_valid   (instr_valid),
  .credit_ret_n  (credit_ret_n),
  .rs1_id        (rs1_id),
  .rs2_id        (rs2_id),
  .rs1_used_id   (rs1_used_id),
  .rs2_used_id   (rs2_used_id),
  .rd_ex         (rd_ex),
  .reg_write_ex  (reg_write_ex),
  .is_ld_ex      (is_ld_ex),
  .data_hazard_id(data_hazard_id),
  .redir_valid   (redir_valid),
  .ex_valid      (ex_valid),
  .mem_valid     (mem_valid),
  .wb_we         (wb_we),
  .retire_valid  (retire_valid),
  .retire_rd     (retire_rd)
);

/* testbench/rv_core_tb.sv */
module rv_core_tb;

  localparam int retire_timeout = 60;
  localparam int tail_cycles = 20;
  localparam int model_step_limit = 1000;

  logic                          clk;
  logic                          arst_n;
  logic                          retire_valid;
  logic [rv_pkg::reg_addr_w-1:0] retire_rd;
  logic [rv_pkg::xlen-1:0]       retire_data;

  // Program image and the architectural state of the reference model
  logic [rv_pkg::xlen-1:0]       prog [rv_pkg::rom_depth];
  logic [rv_pkg::xlen-1:0]       model_regs [32];
  logic [rv_pkg::xlen-1:0]       model_mem [rv_pkg::ram_depth];

  // Expected register writes in program order
  logic [rv_pkg::reg_addr_w-1:0] exp_rd [$];
  logic [rv_pkg::xlen-1:0]       exp_val [$];

  int mismatch_cnt;
  int missing_cnt;
  int extra_cnt;

  rv_core u_rv_core (
    .clk         (clk),
    .arst_n      (arst_n),
    .retire_valid(retire_valid),
    .retire_rd   (retire_rd),
    .retire_data (retire_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Runs the program one instruction at a time until the first all-zero word
  task automatic build_expected();
    rv_pkg::rv_instr_u       w;
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] next_pc;
    logic [rv_pkg::xlen-1:0] a;
    logic [rv_pkg::xlen-1:0] b;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] addr;
    logic [rv_pkg::xlen-1:0] wr_val;
    logic                    wr_en;
    int                      steps;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    for (int i = 0; i < rv_pkg::ram_depth; i++) begin
      model_mem[i] = '0;
    end
    pc = '0;
    steps = 0;
    while ((pc[31:2] < rv_pkg::rom_depth) && (prog[pc[7:2]] != '0)
           && (steps < model_step_limit)) begin
      w = prog[pc[7:2]];
      a = model_regs[w.r.rs1];
      b = model_regs[w.r.rs2];
      imm_i = {{20{w.i.imm12[11]}}, w.i.imm12};
      imm_s = {{20{w.r.funct7[6]}}, w.r.funct7, w.r.rd};
      imm_b = {{19{w.r.funct7[6]}}, w.r.funct7[6], w.r.rd[0], w.r.funct7[5:0],
               w.r.rd[4:1], 1'b0};
      next_pc = pc + 32'd4;
      wr_en = 1'b0;
      wr_val = '0;
      case (w.r.opcode)
        rv_pkg::op_reg: begin
          if ((w.r.funct3 == rv_pkg::f3_add) && (w.r.funct7 == 7'd0)) begin
            wr_en = 1'b1;
            wr_val = a + b;
          end else if ((w.r.funct3 == rv_pkg::f3_add) && (w.r.funct7 == rv_pkg::f7_sub)) begin
            wr_en = 1'b1;
            wr_val = a - b;
          end
        end
        rv_pkg::op_imm: begin
          if (w.i.funct3 == rv_pkg::f3_add) begin
            wr_en = 1'b1;
            wr_val = a + imm_i;
          end
        end
        rv_pkg::op_load: begin
          addr = a + imm_i;
          if (w.i.funct3 == rv_pkg::f3_word) begin
            wr_en = 1'b1;
            wr_val = model_mem[addr[7:2]];
          end
        end
        rv_pkg::op_store: begin
          addr = a + imm_s;
          if (w.r.funct3 == rv_pkg::f3_word) begin
            model_mem[addr[7:2]] = b;
          end
        end
        rv_pkg::op_branch: begin
          if ((w.r.funct3 == rv_pkg::f3_bne) && (a != b)) begin
            next_pc = pc + imm_b;
          end
        end
        default: begin
        end
      endcase
      // x0 stays zero and never shows up on the retire port
      if (wr_en && (w.r.rd != '0)) begin
        model_regs[w.r.rd] = wr_val;
        exp_rd.push_back(w.r.rd);
        exp_val.push_back(wr_val);
      end
      pc = next_pc;
      steps++;
    end
  endtask

  // Outputs settle after the rising edge, so the falling edge is a safe sample point
  task automatic wait_retire(output bit seen);
    int cycles;
    cycles = 0;
    seen = 1'b0;
    while (!seen && (cycles < retire_timeout)) begin
      @(negedge clk);
      cycles++;
      seen = retire_valid;
    end
  endtask

  task automatic compare_retire(input int idx);
    assert ((retire_rd == exp_rd[idx]) && (retire_data == exp_val[idx])) else begin
      $display("Fail at time %0t: retire %0d expected x%0d = %h, seen x%0d = %h",
               $time, idx, exp_rd[idx], exp_val[idx], retire_rd, retire_data);
      mismatch_cnt++;
    end
  endtask

  // Nothing may retire once the expected list is used up
  task automatic check_tail();
    int cycles;
    for (cycles = 0; cycles < tail_cycles; cycles++) begin
      @(negedge clk);
      assert (!retire_valid) else begin
        $display("Fail at time %0t: unexpected retire of x%0d = %h",
                 $time, retire_rd, retire_data);
        extra_cnt++;
      end
    end
  endtask

  initial begin
    int idx;
    bit seen;
    int checker_cnt;
    arst_n = 1'b0;
    mismatch_cnt = 0;
    missing_cnt = 0;
    extra_cnt = 0;
    for (int i = 0; i < rv_pkg::rom_depth; i++) begin
      prog[i] = '0;
    end
    // Same image the fetch ROM loads from the working directory
    $readmemh("program.hex", prog);
    build_expected();
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    idx = 0;
    seen = 1'b1;
    while (seen && (idx < exp_rd.size())) begin
      wait_retire(seen);
      if (seen) begin
        compare_retire(idx);
        idx++;
      end else begin
        missing_cnt = exp_rd.size() - idx;
        $display("Retire %0d of %0d never arrived within %0d cycles",
                 idx, exp_rd.size(), retire_timeout);
      end
    end
    if (seen) begin
      check_tail();
    end
    checker_cnt = u_rv_core.u_rv_core_checker.fail_cnt;
    $display("Errors: %0d mismatched, %0d missing, %0d extra, %0d checker",
             mismatch_cnt, missing_cnt, extra_cnt, checker_cnt);
    if ((mismatch_cnt + missing_cnt + extra_cnt + checker_cnt) == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* testbench/program.hex */
// One RV32I instruction word per line in hex, starting at address 0
// An all-zero word marks the end of the program
00500093
00708113
002081B3
40118233
004202B3
00502423
00802303
001303B3
00702623
00C02403
403404B3
06308013
00208033
00300513
00000593
00458593
FFF50513
FE051CE3
00100613
00C61463
00260693
00069663
06F00713
0DE00793
00168813
00802883
01188933
00000000
00000000
00000000
00000000

/* sim.f */
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_hazard.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_core.sv
testbench/rv_core_checker.sv
testbench/rv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f sim.f --top-module rv_core_tb -o rv_core_tb_sim

# The instruction ROM and the reference model both open program.hex in the working directory
out=$(cd testbench && ../obj_dir/rv_core_tb_sim +verilator+error+limit+100)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
  exit 0
else
  exit 1
fi
